// ==== hdl/frame_pkg.sv ====
// frame store shared definitions

package frame_pkg;

   //////////////////////////////////////////////////
   // memory and video widths
   //////////////////////////////////////////////////

   // one zbt word address, 19 bits covers the whole bank
   typedef logic [18:0] zbt_addr_t;

   // one zbt word, four pixels in the low 32 bits
   // the top nibble is parity space and carries no pixel
   typedef logic [35:0] zbt_word_t;

   // grey pixel byte
   typedef logic [7:0] pixel_t;

   // raster position from the display timing
   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;

   // virtual camera offset
   typedef logic [5:0] cam_offset_t;

   //////////////////////////////////////////////////
   // timing constants
   //////////////////////////////////////////////////

   // pixels packed into one memory word
   localparam int PIXELS_PER_WORD = 4;

   // hcount[1:0] value of the bank 0 write slot
   localparam logic [1:0] WRITE_PHASE = 2'd2;

   // cycles from an address on a bank to its data on the read port
   localparam int READ_LATENCY = 2;

   // idle cycles after each send strobe
   localparam int BYTE_GAP = 16;

   // 1024 x 768 pixels, four per word
   localparam int FRAME_WORDS_DEFAULT = 196608;

   // counter widths derived from the constants above
   localparam int LAT_CNT_W  = $clog2(READ_LATENCY + 1);
   localparam int GAP_CNT_W  = $clog2(BYTE_GAP + 1);
   localparam int BYTE_IDX_W = $clog2(PIXELS_PER_WORD);

   // latency counter inside RD_WAIT
   typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

   // idle cycle counter between strobes
   typedef logic [GAP_CNT_W-1:0] gap_cnt_t;

   // position of the current byte within a word
   typedef logic [BYTE_IDX_W-1:0] byte_idx_t;

   //////////////////////////////////////////////////
   // bank request and readout states
   //////////////////////////////////////////////////

   // one request to a zbt bank, 56 bits
   // we low means a read of addr
   typedef struct packed {
      zbt_addr_t addr;
      logic      we;
      zbt_word_t wdata;
   } mem_req_t;

   // frame readout FSM
   // idle  -> waiting for save, or resting after the frame
   // issue -> one read address on bank 0
   // wait  -> memory latency, word captured at the end
   // send  -> four bytes, each followed by the gap
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ISSUE,
      RD_WAIT,
      RD_SEND
   } readout_state_t;

endpackage

// ==== hdl/frame_readout.sv ====
// frame lock and byte readout

`timescale 1ns/100ps

module frame_readout #(
   parameter int FRAME_WORDS = frame_pkg::FRAME_WORDS_DEFAULT
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                save,
   input  frame_pkg::zbt_word_t rdata,
   output logic                locked,
   output frame_pkg::mem_req_t  rd_req,
   output frame_pkg::pixel_t    tx_byte,
   output logic                tx_send
);

   //////////////////////////////////////////////////
   // state
   //////////////////////////////////////////////////

   frame_pkg::readout_state_t state;
   frame_pkg::zbt_addr_t      word_addr;
   frame_pkg::lat_cnt_t       lat_cnt;
   frame_pkg::gap_cnt_t       gap_cnt;
   frame_pkg::byte_idx_t      byte_idx;
   frame_pkg::zbt_word_t      word_q;

   logic lat_done;
   logic gap_done;
   logic last_byte;
   logic last_word;
   logic capture;
   logic next_byte;

   // byte order on the serial side is 7:0, 31:24, 23:16, 15:8
   function automatic frame_pkg::pixel_t byte_sel(input frame_pkg::zbt_word_t word,
                                                  input frame_pkg::byte_idx_t idx);
      frame_pkg::pixel_t px;
      case (idx)
         2'd0:    px = word[7:0];
         2'd1:    px = word[31:24];
         2'd2:    px = word[23:16];
         default: px = word[15:8];
      endcase
      return px;
   endfunction

   // end of each counted phase
   assign lat_done  = lat_cnt == frame_pkg::lat_cnt_t'(frame_pkg::READ_LATENCY - 1);
   assign gap_done  = gap_cnt == frame_pkg::gap_cnt_t'(frame_pkg::BYTE_GAP);
   assign last_byte = byte_idx == frame_pkg::byte_idx_t'(frame_pkg::PIXELS_PER_WORD - 1);
   assign last_word = word_addr == frame_pkg::zbt_addr_t'(FRAME_WORDS - 1);

   // data path strobes
   assign capture   = (state == frame_pkg::RD_WAIT) && lat_done;
   assign next_byte = (state == frame_pkg::RD_SEND) && gap_done && !last_byte;

   //////////////////////////////////////////////////
   // readout FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         locked    <= 1'b0;
         state     <= frame_pkg::RD_IDLE;
         word_addr <= '0;
         lat_cnt   <= '0;
         gap_cnt   <= '0;
         byte_idx  <= '0;
         tx_send   <= 1'b0;
      end else begin
         // strobe is one cycle wide
         tx_send <= 1'b0;
         case (state)
            frame_pkg::RD_IDLE: begin
               // lock only once, a save while locked does nothing
               if (save && !locked) begin
                  locked    <= 1'b1;
                  word_addr <= '0;
                  state     <= frame_pkg::RD_ISSUE;
               end
            end
            frame_pkg::RD_ISSUE: begin
               lat_cnt <= '0;
               state   <= frame_pkg::RD_WAIT;
            end
            frame_pkg::RD_WAIT: begin
               if (lat_done) begin
                  // first byte goes out together with the capture
                  byte_idx <= '0;
                  gap_cnt  <= '0;
                  tx_send  <= 1'b1;
                  state    <= frame_pkg::RD_SEND;
               end else begin
                  lat_cnt <= lat_cnt + 1'b1;
               end
            end
            frame_pkg::RD_SEND: begin
               if (!gap_done) begin
                  gap_cnt <= gap_cnt + 1'b1;
               end else if (!last_byte) begin
                  byte_idx <= byte_idx + 1'b1;
                  gap_cnt  <= '0;
                  tx_send  <= 1'b1;
               end else if (last_word) begin
                  // whole frame sent, stay locked and quiet
                  state <= frame_pkg::RD_IDLE;
               end else begin
                  word_addr <= word_addr + 1'b1;
                  state     <= frame_pkg::RD_ISSUE;
               end
            end
            default: state <= frame_pkg::RD_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // word capture and byte select
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (capture) begin
         word_q  <= rdata;
         tx_byte <= byte_sel(rdata, '0);
      end else if (next_byte) begin
         tx_byte <= byte_sel(word_q, byte_idx + 1'b1);
      end
   end

   // read only request, used by the arbiter while locked
   assign rd_req.addr  = word_addr;
   assign rd_req.we    = 1'b0;
   assign rd_req.wdata = '0;

endmodule

// ==== hdl/screen_clear.sv ====
// bank 1 screen clear

`timescale 1ns/100ps

module screen_clear #(
   parameter int CLEAR_WORDS = frame_pkg::FRAME_WORDS_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  frame_pkg::cam_offset_t cam_offset,
   input  logic                  blank,
   output logic                  clear_busy,
   output frame_pkg::mem_req_t    clr_req
);

   //////////////////////////////////////////////////
   // offset change detect
   //////////////////////////////////////////////////

   frame_pkg::cam_offset_t prev_offset;
   frame_pkg::zbt_addr_t   clr_addr;

   logic offset_changed;
   logic clr_write;
   logic clr_last;

   // any difference restarts the sweep
   assign offset_changed = cam_offset != prev_offset;

   // zero words go in only during blanking
   assign clr_write = clear_busy && blank;
   assign clr_last  = clr_addr == frame_pkg::zbt_addr_t'(CLEAR_WORDS - 1);

   //////////////////////////////////////////////////
   // sweep counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         prev_offset <= '0;
         clear_busy  <= 1'b0;
         clr_addr    <= '0;
      end else begin
         prev_offset <= cam_offset;
         if (offset_changed) begin
            // a change mid sweep starts over from word 0
            clear_busy <= 1'b1;
            clr_addr   <= '0;
         end else if (clr_write) begin
            // done after the write to the last word
            if (clr_last) begin
               clear_busy <= 1'b0;
            end
            clr_addr <= clr_addr + 1'b1;
         end
      end
   end

   // request toward bank 1
   assign clr_req.addr  = clr_addr;
   assign clr_req.we    = clr_write;
   assign clr_req.wdata = '0;

endmodule

// ==== hdl/zbt_arbiter.sv ====
// zbt bank request arbiter

`timescale 1ns/100ps

module zbt_arbiter (
   input  frame_pkg::hcount_t  hcount,
   input  frame_pkg::vcount_t  vcount,
   input  logic               locked,
   input  frame_pkg::mem_req_t rd_req,
   input  frame_pkg::mem_req_t cam_req,
   input  logic               clear_busy,
   input  frame_pkg::mem_req_t clr_req,
   output frame_pkg::mem_req_t bank0_req,
   output frame_pkg::mem_req_t bank1_req,
   output logic               cam_taken
);

   //////////////////////////////////////////////////
   // display read address
   //////////////////////////////////////////////////

   frame_pkg::mem_req_t disp_req;
   logic                write_slot;

   // one word per four pixels, line number above the word index
   assign disp_req.addr  = {1'b0, vcount, hcount[9:2]};
   assign disp_req.we    = 1'b0;
   assign disp_req.wdata = '0;

   // one phase out of four is free for a write
   assign write_slot = hcount[1:0] == frame_pkg::WRITE_PHASE;

   // camera write accepted only in its slot and only while unlocked
   assign cam_taken = cam_req.we && !locked && write_slot;

   //////////////////////////////////////////////////
   // bank 0
   //////////////////////////////////////////////////

   always_comb begin
      if (locked) begin
         // frame frozen, readout owns the bank and writes are off
         bank0_req    = rd_req;
         bank0_req.we = 1'b0;
      end else if (cam_taken) begin
         bank0_req = cam_req;
      end else begin
         bank0_req = disp_req;
      end
   end

   //////////////////////////////////////////////////
   // bank 1
   //////////////////////////////////////////////////

   always_comb begin
      // a running clear holds the bank even outside blanking
      if (clear_busy) begin
         bank1_req = clr_req;
      end else begin
         bank1_req = disp_req;
      end
   end

endmodule

// ==== hdl/frame_store_top.sv ====
// frame store core

`timescale 1ns/100ps

module frame_store_top #(
   parameter int FRAME_WORDS = frame_pkg::FRAME_WORDS_DEFAULT,
   parameter int CLEAR_WORDS = frame_pkg::FRAME_WORDS_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  save,
   input  frame_pkg::hcount_t     hcount,
   input  frame_pkg::vcount_t     vcount,
   input  logic                  blank,
   input  frame_pkg::cam_offset_t cam_offset,
   input  frame_pkg::mem_req_t    cam_req,
   input  frame_pkg::zbt_word_t   bank0_rdata,
   // display path reads bank 1 outside this core
   input  frame_pkg::zbt_word_t   bank1_rdata,
   output frame_pkg::mem_req_t    bank0_req,
   output frame_pkg::mem_req_t    bank1_req,
   output logic                  cam_taken,
   output logic                  locked,
   output logic                  clear_busy,
   output frame_pkg::pixel_t      tx_byte,
   output logic                  tx_send
);

   //////////////////////////////////////////////////
   // internal requests
   //////////////////////////////////////////////////

   frame_pkg::mem_req_t rd_req;
   frame_pkg::mem_req_t clr_req;

   // frame lock and byte stream from bank 0
   frame_readout #(
      .FRAME_WORDS(FRAME_WORDS)
   ) readout_i (
      .clk    (clk),
      .reset  (reset),
      .save   (save),
      .rdata  (bank0_rdata),
      .locked (locked),
      .rd_req (rd_req),
      .tx_byte(tx_byte),
      .tx_send(tx_send)
   );

   // zero sweep of bank 1 on camera moves
   screen_clear #(
      .CLEAR_WORDS(CLEAR_WORDS)
   ) clear_i (
      .clk       (clk),
      .reset     (reset),
      .cam_offset(cam_offset),
      .blank     (blank),
      .clear_busy(clear_busy),
      .clr_req   (clr_req)
   );

   // per cycle bank ownership
   zbt_arbiter arbiter_i (
      .hcount    (hcount),
      .vcount    (vcount),
      .locked    (locked),
      .rd_req    (rd_req),
      .cam_req   (cam_req),
      .clear_busy(clear_busy),
      .clr_req   (clr_req),
      .bank0_req (bank0_req),
      .bank1_req (bank1_req),
      .cam_taken (cam_taken)
   );

endmodule

// ==== sim/frame_store_assert.sv ====
// frame store bus rules

`timescale 1ns/100ps

module frame_store_assert (
   input logic                clk,
   input logic                reset,
   input logic                locked,
   input logic                tx_send,
   input logic                clear_busy,
   input logic                blank,
   input frame_pkg::mem_req_t bank0_req,
   input frame_pkg::mem_req_t bank1_req
);

   //////////////////////////////////////////////////
   // bank ownership and strobe width
   //////////////////////////////////////////////////

   // frozen frame, no writes into bank 0
   bank0_write_locked: assert property (@(posedge clk) disable iff (reset)
      locked |-> !bank0_req.we)
      else $error("bank 0 write while locked");

   // strobe is a single cycle
   tx_send_width: assert property (@(posedge clk) disable iff (reset)
      tx_send |=> !tx_send)
      else $error("tx_send high for two cycles");

   // clear writes only inside blanking
   bank1_write_blank: assert property (@(posedge clk) disable iff (reset)
      bank1_req.we |-> (clear_busy && blank))
      else $error("bank 1 write outside a clear in blank");

endmodule

bind frame_store_top frame_store_assert assert_i (
   .clk       (clk),
   .reset     (reset),
   .locked    (locked),
   .tx_send   (tx_send),
   .clear_busy(clear_busy),
   .blank     (blank),
   .bank0_req (bank0_req),
   .bank1_req (bank1_req)
);

// ==== sim/frame_store_tb.sv ====
// frame store testbench

`timescale 1ns/100ps

module frame_store_tb;

   //////////////////////////////////////////////////
   // run constants
   //////////////////////////////////////////////////

   localparam int          CLK_PERIOD   = 4;
   localparam int          RESET_CYCLES = 3;
   localparam int          FRAME_WORDS  = 8;
   localparam int          CLEAR_WORDS  = 64;
   localparam logic [31:0] SEED         = 32'h8a47_56a3;

   // short raster lines, blank over the last quarter
   localparam int H_TOTAL   = 64;
   localparam int V_TOTAL   = 16;
   localparam int BLANK_LEN = H_TOTAL / 4;

   // model banks keep only the low address bits
   localparam int MEM_AW = 12;

   localparam int CAM_WRITES   = 4;
   localparam int DISP_CYCLES  = 100;
   localparam int QUIET_CYCLES = 200;

   // test lengths in cycles, the watchdog allows twice their sum
   localparam int WRITE_LEN   = CAM_WRITES * 8;
   localparam int CLEAR_LEN   = CLEAR_WORDS * H_TOTAL / BLANK_LEN + 2 * H_TOTAL;
   localparam int READOUT_LEN = FRAME_WORDS * frame_pkg::PIXELS_PER_WORD
                                * (frame_pkg::BYTE_GAP + 1)
                                + FRAME_WORDS * (2 + frame_pkg::READ_LATENCY);
   localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + WRITE_LEN + DISP_CYCLES
                                         + CLEAR_LEN + READOUT_LEN + QUIET_CYCLES);

   //////////////////////////////////////////////////
   // DUT and signals
   //////////////////////////////////////////////////

   logic                   clk;
   logic                   reset;
   logic                   save;
   frame_pkg::hcount_t     hcount = '0;
   frame_pkg::vcount_t     vcount = '0;
   logic                   blank = 1'b0;
   frame_pkg::cam_offset_t cam_offset;
   frame_pkg::mem_req_t    cam_req;
   frame_pkg::zbt_word_t   bank0_rdata;
   frame_pkg::zbt_word_t   bank1_rdata;
   frame_pkg::mem_req_t    bank0_req;
   frame_pkg::mem_req_t    bank1_req;
   logic                   cam_taken;
   logic                   locked;
   logic                   clear_busy;
   frame_pkg::pixel_t      tx_byte;
   logic                   tx_send;

   // bank contents and read pipelines
   frame_pkg::zbt_word_t bank0_mem [2**MEM_AW];
   frame_pkg::zbt_word_t bank1_mem [2**MEM_AW];
   frame_pkg::zbt_word_t rd0_pipe [frame_pkg::READ_LATENCY] = '{default: '0};
   frame_pkg::zbt_word_t rd1_pipe [frame_pkg::READ_LATENCY] = '{default: '0};

   int errors;
   int stream_errors = 0;
   int strobe_cnt = 0;

   frame_store_top #(
      .FRAME_WORDS(FRAME_WORDS),
      .CLEAR_WORDS(CLEAR_WORDS)
   ) dut_i (
      .clk        (clk),
      .reset      (reset),
      .save       (save),
      .hcount     (hcount),
      .vcount     (vcount),
      .blank      (blank),
      .cam_offset (cam_offset),
      .cam_req    (cam_req),
      .bank0_rdata(bank0_rdata),
      .bank1_rdata(bank1_rdata),
      .bank0_req  (bank0_req),
      .bank1_req  (bank1_req),
      .cam_taken  (cam_taken),
      .locked     (locked),
      .clear_busy (clear_busy),
      .tx_byte    (tx_byte),
      .tx_send    (tx_send)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // raster counters, one pixel per clock
   always @(posedge clk) begin
      #1;
      if (hcount == frame_pkg::hcount_t'(H_TOTAL - 1)) begin
         hcount = '0;
         vcount = (vcount == frame_pkg::vcount_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
      end else begin
         hcount = hcount + 1'b1;
      end
      blank = hcount >= frame_pkg::hcount_t'(H_TOTAL - BLANK_LEN);
   end

   //////////////////////////////////////////////////
   // two-bank memory model
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!reset) begin
         if (bank0_req.we) begin
            bank0_mem[bank0_req.addr[MEM_AW-1:0]] <= bank0_req.wdata;
         end
         if (bank1_req.we) begin
            bank1_mem[bank1_req.addr[MEM_AW-1:0]] <= bank1_req.wdata;
         end
      end
      rd0_pipe[0] <= bank0_mem[bank0_req.addr[MEM_AW-1:0]];
      rd1_pipe[0] <= bank1_mem[bank1_req.addr[MEM_AW-1:0]];
      for (int s = 1; s < frame_pkg::READ_LATENCY; s++) begin
         rd0_pipe[s] <= rd0_pipe[s-1];
         rd1_pipe[s] <= rd1_pipe[s-1];
      end
   end

   assign bank0_rdata = rd0_pipe[frame_pkg::READ_LATENCY-1];
   assign bank1_rdata = rd1_pipe[frame_pkg::READ_LATENCY-1];

   //////////////////////////////////////////////////
   // reference, reporting and stream compare
   //////////////////////////////////////////////////

   // serial order: low byte first, then top byte down to bits 15:8
   function automatic frame_pkg::pixel_t expected_byte(input frame_pkg::zbt_word_t word,
                                                       input int idx);
      case (idx)
         0:       return word[7:0];
         1:       return word[31:24];
         2:       return word[23:16];
         default: return word[15:8];
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
   endtask

   task automatic finish_test(input string name, input int errs);
      $display("test %-12s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
   endtask

   // every strobe is checked against the frozen bank 0 words
   always @(negedge clk) begin
      if (!reset && tx_send) begin
         if (strobe_cnt >= FRAME_WORDS * frame_pkg::PIXELS_PER_WORD) begin
            $display("tx_send strobe after the last byte of the frame at %0t", $time);
            stream_errors++;
         end else if (tx_byte !== expected_byte(bank0_mem[strobe_cnt / 4], strobe_cnt % 4)) begin
            report_mismatch("tx_byte", 64'(tx_byte),
                            64'(expected_byte(bank0_mem[strobe_cnt / 4], strobe_cnt % 4)));
            stream_errors++;
         end
         strobe_cnt++;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      frame_pkg::zbt_addr_t disp;
      frame_pkg::zbt_addr_t clr_next;
      frame_pkg::zbt_word_t held;
      int mark;
      int lat;
      void'($urandom(SEED));
      // both banks start out with random words
      for (int i = 0; i < 2**MEM_AW; i++) begin
         bank0_mem[i] <= frame_pkg::zbt_word_t'({$urandom(), $urandom()});
         bank1_mem[i] <= frame_pkg::zbt_word_t'({$urandom(), $urandom()});
      end
      errors     = 0;
      reset      = 1'b1;
      save       = 1'b0;
      cam_offset = '0;
      cam_req    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;

      // reset state
      mark = errors;
      @(negedge clk);
      if ({locked, clear_busy, tx_send, cam_taken, bank0_req.we, bank1_req.we} !== 6'b0) begin
         report_mismatch("reset outputs", 64'({locked, clear_busy, tx_send, cam_taken,
                         bank0_req.we, bank1_req.we}), 64'(0));
         errors++;
      end
      finish_test("reset", errors - mark);

      // camera writes wait for the write phase
      mark = errors;
      @(posedge clk);
      #1;
      for (int i = 0; i < CAM_WRITES; i++) begin
         cam_req.addr  = frame_pkg::zbt_addr_t'(200 + 7 * i);
         cam_req.wdata = frame_pkg::zbt_word_t'({$urandom(), $urandom()});
         cam_req.we    = 1'b1;
         do begin
            @(negedge clk);
            if (cam_taken !== (hcount[1:0] == frame_pkg::WRITE_PHASE)) begin
               report_mismatch("cam_taken", 64'(cam_taken), 64'(!cam_taken));
               errors++;
            end
         end while (!cam_taken);
         if (bank0_req !== cam_req) begin
            report_mismatch("bank0_req", 64'(bank0_req), 64'(cam_req));
            errors++;
         end
         @(posedge clk);
         #1 cam_req.we = 1'b0;
         if (bank0_mem[cam_req.addr[MEM_AW-1:0]] !== cam_req.wdata) begin
            report_mismatch("bank0_mem", 64'(bank0_mem[cam_req.addr[MEM_AW-1:0]]),
                            64'(cam_req.wdata));
            errors++;
         end
      end
      finish_test("cam_write", errors - mark);

      // idle banks follow the raster
      mark = errors;
      repeat (DISP_CYCLES) begin
         @(negedge clk);
         disp = frame_pkg::zbt_addr_t'({vcount, hcount[9:2]});
         if (bank0_req.addr !== disp) begin
            report_mismatch("bank0_req.addr", 64'(bank0_req.addr), 64'(disp));
            errors++;
         end
         if (bank0_req.we !== 1'b0) begin
            report_mismatch("bank0_req.we", 64'(bank0_req.we), 64'(0));
            errors++;
         end
         if (bank1_req.addr !== disp) begin
            report_mismatch("bank1_req.addr", 64'(bank1_req.addr), 64'(disp));
            errors++;
         end
         if (bank1_req.we !== 1'b0) begin
            report_mismatch("bank1_req.we", 64'(bank1_req.we), 64'(0));
            errors++;
         end
      end
      finish_test("display", errors - mark);

      // offset change sweeps zeros into bank 1 during blank
      mark = errors;
      @(posedge clk);
      #1 cam_offset = 6'd5;
      @(posedge clk);
      #1;
      if (clear_busy !== 1'b1) begin
         report_mismatch("clear_busy", 64'(clear_busy), 64'(1));
         errors++;
      end
      clr_next = '0;
      while (clear_busy) begin
         @(negedge clk);
         if (bank1_req.we) begin
            if (!blank) begin
               $display("bank 1 clear write outside blank at %0t", $time);
               errors++;
            end
            if (bank1_req.addr !== clr_next) begin
               report_mismatch("bank1_req.addr", 64'(bank1_req.addr), 64'(clr_next));
               errors++;
            end
            if (bank1_req.wdata !== '0) begin
               report_mismatch("bank1_req.wdata", 64'(bank1_req.wdata), 64'(0));
               errors++;
            end
            clr_next++;
         end
      end
      if (int'(clr_next) != CLEAR_WORDS) begin
         $display("clear wrote %0d words instead of %0d", clr_next, CLEAR_WORDS);
         errors++;
      end
      for (int i = 0; i < CLEAR_WORDS; i++) begin
         if (bank1_mem[i] !== '0) begin
            report_mismatch("bank1_mem", 64'(bank1_mem[i]), 64'(0));
            errors++;
         end
      end
      finish_test("clear", errors - mark);

      // save locks the frame and starts the byte stream
      mark = errors;
      @(posedge clk);
      #1;
      save = 1'b1;
      lat  = 1;
      @(posedge clk);
      #1 save = 1'b0;
      if (locked !== 1'b1) begin
         report_mismatch("locked", 64'(locked), 64'(1));
         errors++;
      end
      // camera write held against the locked frame
      cam_req.addr  = frame_pkg::zbt_addr_t'(300);
      cam_req.wdata = '1;
      cam_req.we    = 1'b1;
      held          = bank0_mem[300];
      while (!tx_send && lat < 20) begin
         @(posedge clk);
         #1 lat++;
      end
      if (lat != 2 + frame_pkg::READ_LATENCY) begin
         report_mismatch("first tx_send latency", 64'(lat), 64'(2 + frame_pkg::READ_LATENCY));
         errors++;
      end
      while (strobe_cnt < FRAME_WORDS * frame_pkg::PIXELS_PER_WORD) begin
         @(negedge clk);
         if (cam_taken !== 1'b0 || bank0_req.we !== 1'b0) begin
            $display("camera write accepted while locked at %0t", $time);
            errors++;
         end
      end
      // readout rests in idle, a second save must not restart the stream
      repeat (2 * (frame_pkg::BYTE_GAP + 1)) @(posedge clk);
      #1 save = 1'b1;
      @(posedge clk);
      #1 save = 1'b0;
      repeat (QUIET_CYCLES) @(negedge clk);
      if (strobe_cnt != FRAME_WORDS * frame_pkg::PIXELS_PER_WORD) begin
         report_mismatch("tx_send count", 64'(strobe_cnt),
                         64'(FRAME_WORDS * frame_pkg::PIXELS_PER_WORD));
         errors++;
      end
      if (bank0_mem[300] !== held) begin
         report_mismatch("bank0_mem", 64'(bank0_mem[300]), 64'(held));
         errors++;
      end
      if (locked !== 1'b1) begin
         report_mismatch("locked", 64'(locked), 64'(1));
         errors++;
      end
      finish_test("readout", errors - mark + stream_errors);

      $display("tests run: 5, errors: %0d", errors + stream_errors);
      if (errors + stream_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
hdl/frame_pkg.sv
hdl/frame_readout.sv
hdl/screen_clear.sv
hdl/zbt_arbiter.sv
hdl/frame_store_top.sv
sim/frame_store_assert.sv
sim/frame_store_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the frame store testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module frame_store_tb -f build.f -o frame_store_sim \
   && ./obj_dir/frame_store_sim > "$LOG" 2>&1 \
   || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"

# the log decides the result
grep -q "Test FAILED" "$LOG" && exit 1 || exit 0
